/* uart_pkg.sv */
/*
    UART shared definitions: bit timing, APB register map,
    status bit positions and FSM state encodings
*/

package uart_pkg;

    localparam int CLKS_PER_BIT = 4;                    // Clock cycles per serial bit
    localparam int FRAME_BITS   = 11;                   // Start, 8 data, parity, stop
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;     // Offset to the middle of a bit

    localparam int CNT_W = $clog2(CLKS_PER_BIT);        // Cycle counter width
    localparam int BIT_W = $clog2(FRAME_BITS);          // Frame bit index width

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);  // Last cycle of a bit
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(HALF_BIT - 1);      // Middle of the start bit
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(FRAME_BITS - 1);    // Stop bit index

    // APB register map
    typedef enum logic [7:0]
    {
        ADDR_TXDATA = 8'h00,                            // Write only
        ADDR_STATUS = 8'h04,                            // Read only
        ADDR_RXDATA = 8'h08,                            // Read only
        ADDR_CTRL   = 8'h0C                             // Read/write, bit 0 odd parity
    } reg_addr_e;

    localparam int STAT_TX_BUSY    = 0;                 // Frame in flight
    localparam int STAT_RX_VALID   = 1;                 // Byte waiting in RXDATA
    localparam int STAT_PARITY_ERR = 2;                 // Parity mismatch seen
    localparam int STAT_FRAME_ERR  = 3;                 // Stop bit was low
    localparam int STAT_OVERRUN    = 4;                 // Unread byte overwritten

    typedef enum logic {TX_IDLE, TX_SEND} tx_state_e;

    typedef enum logic [2:0]
    {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_e;

endpackage

/* uart_apb_regs.sv */
/*
    UART APB register block: zero wait state decode of TXDATA, STATUS,
    RXDATA and CTRL, transmit start pulse and receive read strobe
*/

module uart_apb_regs
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        tx_start,
    output logic [7:0]  tx_data,
    output logic        parity_odd,
    output logic        rx_read,
    input  logic        tx_busy,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    input  logic        parity_err,
    input  logic        frame_err,
    input  logic        overrun
);

    uart_pkg::reg_addr_e addr;          // paddr seen as a register address
    logic                access;        // APB access phase
    logic                addr_hit;      // Address is mapped
    logic                tx_wr;         // Write to TXDATA
    logic                tx_wr_ok;      // Write to TXDATA accepted
    logic                tx_refused;    // Write to TXDATA while busy
    logic [31:0]         status_word;

    assign addr   = uart_pkg::reg_addr_e'(paddr);
    assign access = psel & penable;
    assign pready = 1'b1;                                       // No wait states

    always_comb
    begin
        case (addr)
            uart_pkg::ADDR_TXDATA,
            uart_pkg::ADDR_STATUS,
            uart_pkg::ADDR_RXDATA,
            uart_pkg::ADDR_CTRL:    addr_hit = 1'b1;
            default:                addr_hit = 1'b0;
        endcase
    end

    // tx_start covers the cycle before tx_busy rises
    assign tx_wr      = access & pwrite & (addr == uart_pkg::ADDR_TXDATA);
    assign tx_refused = tx_wr & (tx_busy | tx_start);
    assign tx_wr_ok   = tx_wr & ~tx_refused;
    assign pslverr    = access & (~addr_hit | tx_refused);
    assign rx_read    = access & ~pwrite & (addr == uart_pkg::ADDR_RXDATA);  // Pops the byte

    always_comb
    begin
        status_word = '0;
        status_word[uart_pkg::STAT_TX_BUSY]    = tx_busy;
        status_word[uart_pkg::STAT_RX_VALID]   = rx_valid;
        status_word[uart_pkg::STAT_PARITY_ERR] = parity_err;
        status_word[uart_pkg::STAT_FRAME_ERR]  = frame_err;
        status_word[uart_pkg::STAT_OVERRUN]    = overrun;
    end

    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            case (addr)
                uart_pkg::ADDR_STATUS: prdata = status_word;
                uart_pkg::ADDR_RXDATA: prdata = {24'd0, rx_data};
                uart_pkg::ADDR_CTRL:   prdata = {31'd0, parity_odd};
                default:               prdata = '0;            // TXDATA and holes read 0
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tx_start   <= 1'b0;
            parity_odd <= 1'b0;                                 // Even parity out of reset
        end
        else
        begin
            tx_start <= tx_wr_ok;                               // One cycle pulse
            if (access && pwrite && addr == uart_pkg::ADDR_CTRL)
                parity_odd <= pwdata[0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_wr_ok)
            tx_data <= pwdata[7:0];                             // Byte for the next frame
    end

endmodule

/* uart_tx.sv */
/*
    UART frame transmitter: start bit, 8 data bits LSB first,
    parity and stop bit, each held for CLKS_PER_BIT cycles
*/

module uart_tx
(
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    input  logic       parity_odd,
    output logic       tx,
    output logic       tx_busy
);

    uart_pkg::tx_state_e            state;
    logic [uart_pkg::CNT_W-1:0]     clk_cnt;        // Cycles into the current bit
    logic [uart_pkg::BIT_W-1:0]     bit_idx;        // Bit now on the line
    logic [uart_pkg::BIT_W-1:0]     bit_next;
    logic                           parity;
    logic [uart_pkg::FRAME_BITS-1:0] frame;         // Frame built from the inputs
    logic [uart_pkg::FRAME_BITS-1:0] frame_q;       // Frame being sent

    assign parity   = (^tx_data) ^ parity_odd;      // Inverted XOR for odd parity
    assign frame    = {1'b1, parity, tx_data, 1'b0}; // Stop, parity, data, start
    assign bit_next = bit_idx + 1'b1;
    assign tx_busy  = (state == uart_pkg::TX_SEND);

    // Inputs may change once the frame is captured
    always_ff @(posedge clk)
    begin
        if (tx_start)
            frame_q <= frame;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= uart_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;                        // Line idles high
        end
        else if (tx_start)
        begin
            state   <= uart_pkg::TX_SEND;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b0;                        // Start bit
        end
        else if (state == uart_pkg::TX_SEND)
        begin
            if (clk_cnt == uart_pkg::CNT_LAST)
            begin
                clk_cnt <= '0;
                if (bit_idx == uart_pkg::BIT_LAST)
                begin
                    state <= uart_pkg::TX_IDLE;     // Stop bit done
                    tx    <= 1'b1;
                end
                else
                begin
                    bit_idx <= bit_next;
                    tx      <= frame_q[bit_next];
                end
            end
            else
            begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

/* uart_rx.sv */
/*
    UART frame receiver: synchronizes rx, samples each bit at its middle,
    checks parity and stop bit, holds the byte with sticky status flags
*/

module uart_rx
(
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    input  logic       parity_odd,
    input  logic       rx_read,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       parity_err,
    output logic       frame_err,
    output logic       overrun
);

    uart_pkg::rx_state_e        state;
    logic                       rx_meta;
    logic                       rx_sync;            // Synchronized serial input
    logic [uart_pkg::CNT_W-1:0] clk_cnt;
    logic [2:0]                 data_idx;           // Data bit being received
    logic [7:0]                 data_sr;            // LSB first shift register
    logic                       par_bad;            // Parity bit mismatch
    logic                       bit_end;            // Middle of a data, parity or stop bit
    logic                       frame_done;

    assign bit_end    = (clk_cnt == uart_pkg::CNT_LAST);
    assign frame_done = (state == uart_pkg::RX_STOP) && bit_end;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= uart_pkg::RX_IDLE;
            clk_cnt  <= '0;
            data_idx <= '0;
        end
        else
        begin
            clk_cnt <= clk_cnt + 1'b1;                  // Wraps once per bit
            case (state)
                uart_pkg::RX_IDLE:
                begin
                    clk_cnt <= '0;
                    if (!rx_sync)
                        state <= uart_pkg::RX_START;    // Possible start edge
                end
                uart_pkg::RX_START:
                begin
                    if (clk_cnt == uart_pkg::CNT_MID)
                    begin
                        clk_cnt  <= '0;
                        data_idx <= '0;
                        state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA:
                begin
                    if (bit_end)
                    begin
                        data_idx <= data_idx + 1'b1;
                        if (data_idx == 3'd7)
                            state <= uart_pkg::RX_PARITY;
                    end
                end
                uart_pkg::RX_PARITY:
                begin
                    if (bit_end)
                        state <= uart_pkg::RX_STOP;
                end
                default:                                // RX_STOP
                begin
                    if (bit_end)
                        state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == uart_pkg::RX_DATA && bit_end)
            data_sr <= {rx_sync, data_sr[7:1]};
        if (state == uart_pkg::RX_PARITY && bit_end)
            par_bad <= rx_sync ^ (^data_sr) ^ parity_odd;
    end

    // A completing frame wins over a read in the same cycle
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_data    <= '0;
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            overrun    <= 1'b0;
        end
        else if (frame_done)
        begin
            rx_data    <= data_sr;                      // Delivered even with errors
            rx_valid   <= 1'b1;
            parity_err <= (parity_err & ~rx_read) | par_bad;
            frame_err  <= (frame_err & ~rx_read) | ~rx_sync;
            overrun    <= (overrun & ~rx_read) | (rx_valid & ~rx_read);
        end
        else if (rx_read)
        begin
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            overrun    <= 1'b0;
        end
    end

endmodule

/* uart_top.sv */
/*
    UART peripheral top: APB register block, transmitter and receiver
*/

module uart_top
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        tx,
    input  logic        rx
);

    logic       tx_start;           // Decode to transmitter
    logic [7:0] tx_data;
    logic       parity_odd;         // Shared by both directions
    logic       tx_busy;
    logic [7:0] rx_data;            // Receiver to decode
    logic       rx_valid;
    logic       parity_err;
    logic       frame_err;
    logic       overrun;
    logic       rx_read;

    uart_apb_regs i_uart_apb_regs
    (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .parity_odd (parity_odd),
        .rx_read    (rx_read),
        .tx_busy    (tx_busy),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .parity_err (parity_err),
        .frame_err  (frame_err),
        .overrun    (overrun)
    );

    uart_tx i_uart_tx
    (
        .clk        (clk),
        .reset      (reset),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .parity_odd (parity_odd),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

    uart_rx i_uart_rx
    (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .parity_odd (parity_odd),
        .rx_read    (rx_read),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .parity_err (parity_err),
        .frame_err  (frame_err),
        .overrun    (overrun)
    );

endmodule

/* uart_sva.sv */
/*
    UART bound checks: APB ready, transmit start against busy,
    idle line level and known read data
*/

module uart_sva
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        tx_start,
    input  logic        tx_busy,
    input  logic        tx
);

    ready_high: assert property (@(posedge clk) disable iff (reset) pready)
        else $error("pready low, slave inserted a wait state");

    start_when_idle: assert property (@(posedge clk) disable iff (reset) !(tx_start && tx_busy))
        else $error("tx_start pulsed while a frame was in flight");

    line_idle_high: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> tx)
        else $error("tx low while the transmitter is idle");

    read_data_known: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pwrite) |-> !$isunknown(prdata))
        else $error("prdata has X or Z bits in a read access");

endmodule

bind uart_top uart_sva i_uart_sva
(
    .clk      (clk),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .prdata   (prdata),
    .pready   (pready),
    .tx_start (tx_start),           // Internal decode to transmitter pulse
    .tx_busy  (tx_busy),
    .tx       (tx)
);

/* tb_uart.sv */
/*
    UART testbench driving APB register accesses, loopback frames and
    injected receive frames, operations and expected values from the stim file
*/

module tb_uart;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int BIT_CLKS     = uart_pkg::CLKS_PER_BIT;
    localparam int FRAME_BITS   = uart_pkg::FRAME_BITS;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        tx;
    logic        rx;
    logic        rx_drv;                    // Bit-bang level for rx
    logic        loopback;                  // tx fed back into rx
    logic        ctrl_odd;                  // Expected CTRL bit 0

    logic [7:0]  op_q[$];                   // Stim columns
    logic [31:0] arg_q[$];
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] err_q[$];

    int unsigned cycle_cnt;
    int unsigned cycle_limit;               // Zero until the stim is loaded

    assign rx = loopback ? tx : rx_drv;

    uart_top i_uart_top
    (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .tx      (tx),
        .rx      (rx)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run stopped on error");
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
            abort_run($sformatf("Timeout: test still running after %0d cycles", cycle_cnt));
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                                $time, name, expected, actual));
    endtask

    // Start, 8 data LSB first, parity, stop
    function automatic logic [FRAME_BITS-1:0] expected_frame(input logic [7:0] data,
        input logic odd, input logic bad_parity, input logic low_stop);
        logic par;
        int   i;
        par = odd;                          // Odd parity inverts the XOR
        for (i = 0; i < 8; i++)
            par = par ^ data[i];
        return {~low_stop, par ^ bad_parity, data, 1'b0};
    endfunction

    task automatic apb_access(input logic is_write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;                     // Setup phase
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = is_write ? wdata : 32'd0;
        @(negedge clk);
        penable = 1'b1;                     // Access phase
        #(CLK_PERIOD/4);
        rdata = prdata;                     // Settled combinational response
        err   = pslverr;
        check("pready", 32'd1, 32'(pready));    // Zero wait states
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_frame(input logic [FRAME_BITS-1:0] frame);
        int i;
        @(negedge clk);
        loopback = 1'b0;
        for (i = 0; i < FRAME_BITS; i++)
        begin
            rx_drv = frame[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx_drv   = 1'b1;                    // Back to idle line
        loopback = 1'b1;
    endtask

    task automatic watch_frame(input logic [FRAME_BITS-1:0] frame);
        int i;
        while (tx !== 1'b0)
            @(negedge clk);                 // Start bit edge
        repeat (BIT_CLKS/2) @(negedge clk);
        for (i = 0; i < FRAME_BITS; i++)
        begin
            check($sformatf("tx bit %0d", i), 32'(frame[i]), 32'(tx));
            if (i < FRAME_BITS - 1)
                repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    // rx_valid and flags settle one edge after the receiver ends a frame
    task automatic wait_rx_done();
        while (!i_uart_top.i_uart_rx.frame_done)
            @(negedge clk);
        @(negedge clk);
    endtask

    initial
    begin
        int          fd;
        int          n;
        int          k;
        string       line;
        logic [7:0]  op;
        logic [31:0] f_arg;
        logic [31:0] f_data;
        logic [31:0] f_exp;
        logic [31:0] f_err;
        logic [31:0] rdata;
        logic [31:0] rdata_clash;
        logic        err;
        logic        err_clash;

        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 8'd0;
        pwdata      = 32'd0;
        rx_drv      = 1'b1;
        loopback    = 1'b1;
        ctrl_odd    = 1'b0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        void'($urandom(32'haed2_7ea3));

        fd = $fopen("uart_stim.txt", "r");
        if (fd == 0)
            abort_run("Could not open the stimulus file uart_stim.txt");
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%c %h %h %h %h", op, f_arg, f_data, f_exp, f_err);
            if (n == 5 && (op == "W" || op == "R" || op == "I" || op == "T"))
            begin
                op_q.push_back(op);
                arg_q.push_back(f_arg);
                data_q.push_back(f_data);
                exp_q.push_back(f_exp);
                err_q.push_back(f_err);
            end
        end
        $fclose(fd);
        cycle_limit = op_q.size() * (FRAME_BITS * BIT_CLKS + 20);

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check("tx", 32'd1, 32'(tx));        // Idle line out of reset

        for (k = 0; k < op_q.size(); k++)
        begin
            case (op_q[k])
                "W":
                begin
                    apb_access(1'b1, 8'(arg_q[k]), data_q[k], rdata, err);
                    check("pslverr", err_q[k], 32'(err));
                    if (!err && 8'(arg_q[k]) == uart_pkg::ADDR_CTRL)
                        ctrl_odd = data_q[k][0];
                end
                "R":
                begin
                    apb_access(1'b0, 8'(arg_q[k]), 32'd0, rdata, err);
                    check("pslverr", err_q[k], 32'(err));
                    check("prdata", exp_q[k], rdata);
                end
                "I":
                begin
                    send_frame(expected_frame(8'(arg_q[k]), ctrl_odd,
                                              data_q[k][0], data_q[k][1]));
                    wait_rx_done();
                end
                "T":
                begin
                    apb_access(1'b1, uart_pkg::ADDR_TXDATA, arg_q[k], rdata, err);
                    check("pslverr", 32'd0, 32'(err));
                    fork
                        watch_frame(expected_frame(8'(arg_q[k]), ctrl_odd, 1'b0, 1'b0));
                        if (data_q[k] != 32'd0)
                        begin
                            repeat (2 * BIT_CLKS) @(negedge clk);  // Mid frame
                            apb_access(1'b1, uart_pkg::ADDR_TXDATA, data_q[k],
                                       rdata_clash, err_clash);
                            check("pslverr", err_q[k], 32'(err_clash));
                        end
                    join
                    wait_rx_done();         // Loopback copy received
                end
                default:
                    abort_run("Unknown opcode in the stimulus file");
            endcase
            repeat ($urandom_range(4, 1)) @(negedge clk);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* uart_stim.txt */
# op addr/byte data/flag expected pslverr, hex; W write, R read, I inject, T transmit
# I flag 1 wrong parity, 2 low stop; T data is a byte written mid frame, 0 for none
R 04 00000000 00000000 0
R 0C 00000000 00000000 0
R 00 00000000 00000000 0
T A5 00000000 00000000 0
R 04 00000000 00000002 0
R 08 00000000 000000A5 0
R 04 00000000 00000000 0
W 0C 00000001 00000000 0
R 0C 00000000 00000001 0
T 3C 00000000 00000000 0
R 04 00000000 00000002 0
R 08 00000000 0000003C 0
R 04 00000000 00000000 0
T 81 0000005A 00000000 1
R 08 00000000 00000081 0
R 10 00000000 00000000 1
W 10 00000001 00000000 1
W 0C 00000000 00000000 0
I 96 00000001 00000000 0
R 04 00000000 00000006 0
R 08 00000000 00000096 0
R 04 00000000 00000000 0
I 42 00000002 00000000 0
R 04 00000000 0000000A 0
R 08 00000000 00000042 0
I 11 00000000 00000000 0
I 22 00000000 00000000 0
R 04 00000000 00000012 0
R 08 00000000 00000022 0
R 04 00000000 00000000 0

/* sim.f */
uart_pkg.sv
uart_apb_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_sva.sv
tb_uart.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_uart -f sim.f -o tb_uart_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_uart_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1
